// File: design/tri_cfg_pkg.sv
// triangle dds command bus
package tri_cfg_pkg;

    localparam int CMD_DATA_W = 24;
    localparam int CHAN_W     = 2;
    // fall flag position in an OP_SET_START payload
    localparam int START_FALL_BIT = 8;

    // command opcodes
    typedef enum logic [2:0] {
        OP_NOP       = 3'd0,
        OP_SET_FREQ  = 3'd1,
        OP_SET_AMP   = 3'd2,
        OP_SET_START = 3'd3,
        OP_SET_DECIM = 3'd4,
        OP_COMMIT    = 3'd5
    } cfg_op_e;

    // one strobed command
    typedef struct packed {
        cfg_op_e               op;
        logic [CHAN_W-1:0]     chan;
        // freq, amp, start point or decimation, by opcode
        logic [CMD_DATA_W-1:0] data;
    } cfg_cmd_t;

endpackage

// File: design/tri_cfg_regs.sv
// command decode and shadow registers
`timescale 1ns/1ps

module tri_cfg_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_valid,
    input  tri_cfg_pkg::cfg_cmd_t         cfg_cmd,
    output tri_dds_pkg::ch_cfg_t          ch_cfg [tri_dds_pkg::NUM_CH],
    output logic [tri_dds_pkg::DEC_W-1:0] decim,
    output logic                          restart
);
    import tri_dds_pkg::*;
    import tri_cfg_pkg::*;

    // staged settings, not seen by the channels until commit
    ch_cfg_t          shd_cfg [NUM_CH];
    logic [DEC_W-1:0] shd_decim;
    logic             commit;

    assign commit = cfg_valid && (cfg_cmd.op == OP_COMMIT);

    // shadow writes by opcode and channel index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                shd_cfg[i] <= '0;
            end
            shd_decim <= '0;
        end else if (cfg_valid) begin
            case (cfg_cmd.op)
                OP_NOP: begin
                end
                OP_SET_FREQ: begin
                    shd_cfg[cfg_cmd.chan].freq <= cfg_cmd.data[PH_W-1:0];
                end
                OP_SET_AMP: begin
                    shd_cfg[cfg_cmd.chan].amp <= cfg_cmd.data[DT_W-1:0];
                end
                OP_SET_START: begin
                    // level in the low byte, fall flag just above
                    shd_cfg[cfg_cmd.chan].start_level <= cfg_cmd.data[DT_W-1:0];
                    shd_cfg[cfg_cmd.chan].start_fall  <= cfg_cmd.data[START_FALL_BIT];
                end
                OP_SET_DECIM: begin
                    shd_decim <= cfg_cmd.data[DEC_W-1:0];
                end
                OP_COMMIT: begin
                    // transfer happens in the active copy below
                end
                default: begin
                    // undefined opcodes are dropped
                end
            endcase
        end
    end

    // active copy, all channels updated on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                ch_cfg[i] <= '0;
            end
            decim   <= '0;
            restart <= 1'b0;
        end else begin
            // restart follows the commit strobe by one cycle
            restart <= commit;
            if (commit) begin
                for (int i = 0; i < NUM_CH; i++) begin
                    ch_cfg[i] <= shd_cfg[i];
                end
                decim <= shd_decim;
            end
        end
    end

    // channels and capture expect a single-cycle restart
    restart_pulse_a: assert property (
        @(posedge clk) disable iff (!rst_n) restart |=> !restart
    );

endmodule

// File: design/tri_channel.sv
// reflecting triangle channel
`timescale 1ns/1ps

module tri_channel (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         restart,
    input  tri_dds_pkg::ch_cfg_t         cfg,
    output logic [tri_dds_pkg::DT_W-1:0] sample
);
    import tri_dds_pkg::*;

    logic [PH_W-1:0] phase;
    dir_e            dir;
    // one extra bit so a wrap past the top is still seen as above the peak
    logic [PH_W:0]   rise_sum;
    logic [PH_W:0]   peak;
    logic [PH_W-1:0] start_phase;

    assign rise_sum    = {1'b0, phase} + {1'b0, cfg.freq};
    assign peak        = {1'b0, cfg.amp, {FRAC_W{1'b0}}};
    assign start_phase = {cfg.start_level, {FRAC_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
            dir   <= RISE;
        end else if (restart) begin
            phase <= start_phase;
            dir   <= cfg.start_fall ? FALL : RISE;
        end else begin
            case (dir)
                RISE: begin
                    // clamp at the peak, never overshoot
                    if (rise_sum >= peak) begin
                        phase <= peak[PH_W-1:0];
                        dir   <= FALL;
                    end else begin
                        phase <= rise_sum[PH_W-1:0];
                    end
                end
                FALL: begin
                    // clamp at zero instead of wrapping below it
                    if (cfg.freq > phase) begin
                        phase <= '0;
                        dir   <= RISE;
                    end else begin
                        phase <= phase - cfg.freq;
                    end
                end
            endcase
        end
    end

    // sample is the top of the phase, no output register
    assign sample = phase[PH_W-1 -: DT_W];

    // restart loads a level at or below the peak, so the ramp stays inside it
    in_range_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!restart && cfg.start_level <= cfg.amp) |-> (sample <= cfg.amp)
    );

    // turning back up only happens from the zero clamp
    floor_turn_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dir == FALL && !restart) ##1 (dir == RISE) |-> (sample == '0)
    );

endmodule

// File: design/tri_dds_pkg.sv
// triangle dds shared types
package tri_dds_pkg;

    // channel count and datapath widths
    localparam int NUM_CH = 4;
    localparam int PH_W   = 24;
    localparam int DT_W   = 8;
    localparam int DEC_W  = 16;
    // phase bits below the sample
    localparam int FRAC_W = PH_W - DT_W;

    // ramp direction of one channel
    typedef enum logic {
        RISE = 1'b0,
        FALL = 1'b1
    } dir_e;

    // settings of one channel
    typedef struct packed {
        logic [PH_W-1:0] freq;
        // peak sample value
        logic [DT_W-1:0] amp;
        // sample value and direction loaded at restart
        logic [DT_W-1:0] start_level;
        logic            start_fall;
    } ch_cfg_t;

    // one sample per channel, channel 0 in the low byte
    typedef logic [NUM_CH-1:0][DT_W-1:0] tri_frame_t;

endpackage

// File: design/tri_dds_top.sv
// four-channel triangle generator
`timescale 1ns/1ps

module tri_dds_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_valid,
    input  tri_cfg_pkg::cfg_cmd_t   cfg_cmd,
    output tri_dds_pkg::tri_frame_t frame,
    output logic                    frame_valid
);
    import tri_dds_pkg::*;

    ch_cfg_t          ch_cfg [NUM_CH];
    logic [DEC_W-1:0] decim;
    logic             restart;
    logic [DT_W-1:0]  samples [NUM_CH];

    // command decode, shadow and active settings
    tri_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_cmd   (cfg_cmd),
        .ch_cfg    (ch_cfg),
        .decim     (decim),
        .restart   (restart)
    );

    // one accumulator per channel, all restarted together
    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        tri_channel u_channel (
            .clk     (clk),
            .rst_n   (rst_n),
            .restart (restart),
            .cfg     (ch_cfg[i]),
            .sample  (samples[i])
        );
    end

    tri_frame_capture u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .restart     (restart),
        .decim       (decim),
        .samples     (samples),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

endmodule

// File: design/tri_frame_capture.sv
// decimated frame capture
`timescale 1ns/1ps

module tri_frame_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          restart,
    input  logic [tri_dds_pkg::DEC_W-1:0] decim,
    input  logic [tri_dds_pkg::DT_W-1:0]  samples [tri_dds_pkg::NUM_CH],
    output tri_dds_pkg::tri_frame_t       frame,
    output logic                          frame_valid
);
    import tri_dds_pkg::*;

    logic [DEC_W-1:0] dec_cnt;
    // no frames until the first restart
    logic             running;
    logic             tick;

    assign tick = running && (dec_cnt == decim);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_cnt     <= '0;
            running     <= 1'b0;
            frame_valid <= 1'b0;
            frame       <= '0;
        end else if (restart) begin
            dec_cnt     <= '0;
            running     <= 1'b1;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= tick;
            if (tick) begin
                dec_cnt <= '0;
                // all channels on the same edge, one coherent slice
                for (int i = 0; i < NUM_CH; i++) begin
                    frame[i] <= samples[i];
                end
            end else if (running) begin
                dec_cnt <= dec_cnt + 1'b1;
            end
        end
    end

    // with decimation the counter needs decim+1 cycles to come round again
    frame_pulse_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (frame_valid && decim != '0) |=> !frame_valid
    );

endmodule

// File: dv/tri_dds_tb.sv
// triangle dds testbench
`timescale 1ns/1ps

module tri_dds_tb;
    import tri_dds_pkg::*;
    import tri_cfg_pkg::*;

    // spare cycles per record on top of its frames
    localparam int MARGIN = 20;

    logic       clk;
    logic       rst_n;
    logic       cfg_valid;
    cfg_cmd_t   cfg_cmd;
    tri_frame_t frame;
    logic       frame_valid;

    // reference model state as it stands after the latest rising edge
    logic [PH_W-1:0]  m_phase [NUM_CH];
    dir_e             m_dir [NUM_CH];
    ch_cfg_t          m_shd [NUM_CH];
    ch_cfg_t          m_act [NUM_CH];
    logic [DEC_W-1:0] m_shd_decim;
    logic [DEC_W-1:0] m_decim;
    logic [DEC_W-1:0] m_cnt;
    logic             m_restart;
    logic             m_running;
    logic             m_fv;
    tri_frame_t       m_frame;

    // bookkeeping of the record being run
    logic [127:0] cur_name;
    logic [31:0]  cur_exp;
    logic         cur_has_exp;
    logic         first_due;
    int           dut_frames;
    int           cyc;
    int           limit;
    int           err_val;
    int           err_ctl;
    logic [15:0]  lfsr;

    tri_dds_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_valid   (cfg_valid),
        .cfg_cmd     (cfg_cmd),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois step with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit with the first bit ending up on top
    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // one rising edge of the whole design
    task automatic model_edge();
        logic [PH_W:0] sum;
        logic [PH_W:0] peak;
        // capture looks at the samples from before this edge
        if (m_restart) begin
            m_cnt      = '0;
            m_running  = 1'b1;
            m_fv       = 1'b0;
            dut_frames = 0;
            first_due  = 1'b1;
        end else begin
            m_fv = m_running && (m_cnt == m_decim);
            if (m_fv) begin
                m_cnt = '0;
                for (int i = 0; i < NUM_CH; i++) begin
                    m_frame[i] = m_phase[i][PH_W-1 -: DT_W];
                end
            end else if (m_running) begin
                m_cnt = m_cnt + 16'd1;
            end
        end
        // channels reflect at the peak and at zero
        for (int i = 0; i < NUM_CH; i++) begin
            sum  = {1'b0, m_phase[i]} + {1'b0, m_act[i].freq};
            peak = {1'b0, m_act[i].amp, {FRAC_W{1'b0}}};
            if (m_restart) begin
                m_phase[i] = {m_act[i].start_level, {FRAC_W{1'b0}}};
                m_dir[i]   = m_act[i].start_fall ? FALL : RISE;
            end else if (m_dir[i] == RISE) begin
                if (sum >= peak) begin
                    m_phase[i] = peak[PH_W-1:0];
                    m_dir[i]   = FALL;
                end else begin
                    m_phase[i] = sum[PH_W-1:0];
                end
            end else if (m_act[i].freq > m_phase[i]) begin
                m_phase[i] = '0;
                m_dir[i]   = RISE;
            end else begin
                m_phase[i] = m_phase[i] - m_act[i].freq;
            end
        end
        // commit moves the shadow copy and restart lands one edge later
        m_restart = cfg_valid && (cfg_cmd.op == OP_COMMIT);
        if (m_restart) begin
            for (int i = 0; i < NUM_CH; i++) begin
                m_act[i] = m_shd[i];
            end
            m_decim = m_shd_decim;
        end
    endtask

    task automatic check_outputs();
        assert (frame_valid == m_fv) else begin
            $display("ERROR %0s frame_valid expected %0b actual %0b",
                     cur_name, m_fv, frame_valid);
            err_val++;
        end
        if (frame_valid) begin
            dut_frames++;
            for (int i = 0; i < NUM_CH; i++) begin
                assert (frame[i] == m_frame[i]) else begin
                    $display("ERROR %0s ch%0d sample expected %02h actual %02h",
                             cur_name, i, m_frame[i], frame[i]);
                    err_val++;
                end
            end
            if (first_due && cur_has_exp) begin
                assert (frame == cur_exp) else begin
                    $display("ERROR %0s first frame expected %08h actual %08h",
                             cur_name, cur_exp, frame);
                    err_val++;
                end
            end
            first_due = 1'b0;
        end
    endtask

    // inputs are sampled at the rising edge and the model steps at the falling one
    task automatic cycle();
        @(posedge clk);
        @(negedge clk);
        model_edge();
        check_outputs();
    endtask

    task automatic send(input cfg_op_e op, input logic [1:0] chan, input logic [23:0] data);
        // shadow copy is only read at a later commit
        case (op)
            OP_SET_FREQ:  m_shd[chan].freq = data;
            OP_SET_AMP:   m_shd[chan].amp = data[7:0];
            OP_SET_START: begin
                m_shd[chan].start_level = data[7:0];
                m_shd[chan].start_fall  = data[8];
            end
            OP_SET_DECIM: m_shd_decim = data[15:0];
            default: begin
            end
        endcase
        cfg_valid    = 1'b1;
        cfg_cmd.op   = op;
        cfg_cmd.chan = chan;
        cfg_cmd.data = data;
        limit += 1;
        cycle();
        cfg_valid = 1'b0;
        cfg_cmd   = '0;
    endtask

    // the first cycle covers the restart edge before DUT frames are counted
    task automatic wait_frames(input int frames);
        limit += frames * (int'(m_shd_decim) + 1) + MARGIN;
        cycle();
        while (dut_frames < frames) begin
            cycle();
        end
    endtask

    task automatic run_random(input int frames, input int dec);
        logic [31:0] v;
        logic [7:0]  amp;
        for (int i = 0; i < NUM_CH; i++) begin
            draw(20, v);
            send(OP_SET_FREQ, 2'(i), v[23:0]);
            draw(8, v);
            amp = v[7:0];
            send(OP_SET_AMP, 2'(i), {16'h0, amp});
            // masking with amp keeps the start level inside the ramp
            draw(9, v);
            send(OP_SET_START, 2'(i), {15'h0, v[8], v[7:0] & amp});
        end
        send(OP_SET_DECIM, 2'd0, dec[23:0]);
        send(OP_COMMIT, 2'd0, 24'h0);
        wait_frames(frames);
    endtask

    // cycle limit grows as records are read
    initial begin
        cyc = 0;
        while (cyc <= limit) begin
            @(posedge clk);
            cyc++;
        end
        $display("timed out after %0d cycles in test %0s, a frame never arrived",
                 cyc, cur_name);
        $display("errors: %0d value mismatches, %0d other failures", err_val, err_ctl);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [8*96-1:0] line;
        logic [63:0]     kw;
        logic [31:0]     h;
        int              fd;
        int              n;
        int              a;
        int              b;
        rst_n       = 1'b0;
        cfg_valid   = 1'b0;
        cfg_cmd     = '0;
        m_shd_decim = '0;
        m_decim     = '0;
        m_cnt       = '0;
        m_restart   = 1'b0;
        m_running   = 1'b0;
        m_fv        = 1'b0;
        m_frame     = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            m_phase[i] = '0;
            m_dir[i]   = RISE;
            m_shd[i]   = '0;
            m_act[i]   = '0;
        end
        cur_name    = "reset";
        cur_exp     = '0;
        cur_has_exp = 1'b0;
        first_due   = 1'b0;
        dut_frames  = 0;
        err_val     = 0;
        err_ctl     = 0;
        limit       = 3 + MARGIN;
        lfsr        = 16'd34577;
        fd = $fopen("dv/tri_input.txt", "r");
        assert (fd != 0) else begin
            $display("could not open dv/tri_input.txt for reading");
            err_ctl++;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        while (fd != 0 && !$feof(fd)) begin
            line = '0;
            kw   = '0;
            if ($fgets(line, fd) == 0) break;
            n = $sscanf(line, "%s", kw);
            if (n < 1 || kw == "#") continue;
            if (kw == "test") begin
                n = $sscanf(line, "%s %s %d %h", kw, cur_name, a, cur_exp);
                cur_has_exp = 1'b1;
                b = a;
            end else if (kw == "idle") begin
                n = $sscanf(line, "%s %s %d", kw, cur_name, a);
                limit += a + MARGIN;
                for (int k = 0; k < a; k++) begin
                    cycle();
                    assert (frame == '0) else begin
                        $display("ERROR %0s frame expected %08h actual %08h",
                                 cur_name, 32'h0, frame);
                        err_val++;
                    end
                end
            end else if (kw == "random") begin
                n = $sscanf(line, "%s %s %d %d", kw, cur_name, a, b);
                cur_has_exp = 1'b0;
                run_random(a, b);
            end else if (kw == "freq" || kw == "amp" || kw == "start" || kw == "decim") begin
                n = $sscanf(line, "%s %d %h", kw, a, h);
                send(kw == "freq" ? OP_SET_FREQ : kw == "amp" ? OP_SET_AMP :
                     kw == "start" ? OP_SET_START : OP_SET_DECIM, 2'(a), h[23:0]);
            end else if (kw == "commit") begin
                send(OP_COMMIT, 2'd0, 24'h0);
                wait_frames(b);
            end else begin
                $display("unknown record %0s in dv/tri_input.txt", kw);
                err_ctl++;
            end
        end
        if (fd != 0) $fclose(fd);
        $display("errors: %0d value mismatches, %0d other failures", err_val, err_ctl);
        if (err_val == 0 && err_ctl == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dv/tri_input.txt
# test <name> <frames> <first frame hex, ch3 in the top byte>, then <op> <chan> <data hex>
# op is freq amp start decim commit, start data is fall flag in bit 8 and level below
# idle <name> <cycles> and random <name> <frames> <decim> are records on their own
idle after_reset 10
test single_ramp 14 00000000
freq 0 0c0000
amp 0 40
commit 0 0
test independent 8 40201008
freq 1 080000
freq 2 100000
freq 3 200000
amp 1 30
amp 2 80
amp 3 f0
freq 0 040000
amp 0 20
decim 0 2
commit 0 0
test start_points 10 20100c04
freq 1 040000
amp 1 20
start 1 110
decim 0 1
commit 0 0
test decim_commit 6 6030040c
decim 0 3
commit 0 0
test late_writes 6 60600430
freq 0 100000
amp 0 ff
start 2 080
start 3 1c0
commit 0 0
random rand_a 6 2
random rand_b 5 0
random rand_c 4 5

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the triangle dds testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tri_dds_sim

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tri_dds_tb --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi
echo "simulation clean, see $LOG"
exit 0

// File: sim.f
design/tri_dds_pkg.sv
design/tri_cfg_pkg.sv
design/tri_cfg_regs.sv
design/tri_channel.sv
design/tri_frame_capture.sv
design/tri_dds_top.sv
dv/tri_dds_tb.sv
